// ==== vlog.f ====
source/alu_pkg.sv
source/reg_file_2r1w.sv
source/alu_issue.sv
source/alu_execute.sv
source/alu_writeback.sv
source/alu_unit_top.sv
bench/tb_clock_gen.sv
bench/tb_alu_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_alu_unit \
    && ./obj_dir/Vtb_alu_unit > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== bench/tb_alu_unit.sv ====
module tb_alu_unit;
    import alu_pkg::*;

    logic     _wr_en;
    logic     arst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // architectural state as sequential execution would leave it
    data_t       model_regs [reg_count];
    flags_t      model_flags;
    logic [31:0] lfsr_state;

    tb_clock_gen i_tb_clock_gen (
        ._wr_en (_wr_en),
        .arst_n (arst_n)
    );

    alu_unit_top i_alu_unit_top (
        ._wr_en  (_wr_en),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // every bit taken costs one step of the LFSR
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_slverr(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("** Error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!arst_n && cycles < 20) begin
            @(posedge _wr_en);
            cycles++;
        end
        if (!arst_n) begin
            report_failure("reset was never released");
        end
        @(posedge _wr_en);
        #1;
    endtask

    // one APB transfer runs a setup cycle and then access cycles until pready
    // pready is looked at on the falling edge where the response has settled
    task automatic apb_transfer(input logic write, input paddr_t addr,
                                input logic [apb_w-1:0] wdata,
                                output logic [apb_w-1:0] rdata, output logic slverr);
        int   cycles;
        logic done;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge _wr_en);
        #1;
        apb_req.penable = 1'b1;
        done   = 1'b0;
        rdata  = '0;
        slverr = 1'b0;
        cycles = 0;
        while (!done && cycles < 50) begin
            @(negedge _wr_en);
            if (apb_rsp.pready) begin
                rdata  = apb_rsp.prdata;
                slverr = apb_rsp.pslverr;
                done   = 1'b1;
            end
            @(posedge _wr_en);
            #1;
            cycles++;
        end
        if (!done) begin
            report_failure($sformatf("pready never rose for address %h", addr));
        end
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // carry is the carry out, the borrow or the bit shifted out
    task automatic model_execute(input logic [3:0] op, input reg_addr_t dst,
                                 input reg_addr_t src_l, input reg_addr_t src_r);
        data_t l;
        data_t r;
        data_t res;
        logic  c;
        int    sum;
        l   = model_regs[src_l];
        r   = model_regs[src_r];
        c   = 1'b0;
        res = '0;
        case (op)
            op_add: begin
                sum = int'(l) + int'(r);
                res = data_t'(sum);
                c   = sum > 255;
            end
            op_sub: begin
                res = l - r;
                c   = l < r;
            end
            op_and: res = l & r;
            op_or:  res = l | r;
            op_xor: res = l ^ r;
            op_mov: res = l;
            op_shl: begin
                res = l << 1;
                c   = l[7];
            end
            op_shr: begin
                res = l >> 1;
                c   = l[0];
            end
            default: res = '0;
        endcase
        model_regs[dst]   = res;
        model_flags.carry = c;
        model_flags.zero  = res == 8'h00;
    endtask

    // the six low bits are don't care and get random filler
    function automatic logic [apb_w-1:0] instr_word(input logic [3:0] op, input reg_addr_t dst,
                                                    input reg_addr_t src_l,
                                                    input reg_addr_t src_r);
        return {op, dst, src_l, src_r, 6'(rand_bits(6))};
    endfunction

    task automatic write_check(input paddr_t addr, input logic [apb_w-1:0] wdata);
        logic [apb_w-1:0] rdata;
        logic             slverr;
        instr_t           w;
        w = instr_t'(wdata);
        apb_transfer(1'b1, addr, wdata, rdata, slverr);
        if (addr < addr_instr) begin
            check_slverr("pslverr", 1'b0, slverr);
            model_regs[reg_addr_t'(addr - addr_reg_base)] = wdata[7:0];
        end else if (addr == addr_instr) begin
            // opcodes above shr are rejected and leave the state alone
            check_slverr("pslverr", w.op > 4'd7, slverr);
            if (w.op <= 4'd7) begin
                model_execute(w.op, w.dst, w.src_l, w.src_r);
            end
        end else begin
            check_slverr("pslverr", addr != addr_flags, slverr);
        end
    endtask

    task automatic read_check(input paddr_t addr);
        logic [apb_w-1:0] rdata;
        logic             slverr;
        apb_transfer(1'b0, addr, '0, rdata, slverr);
        if (addr < addr_instr) begin
            check_slverr("pslverr", 1'b0, slverr);
            check_data("prdata[15:8]", '0, rdata[15:8]);
            check_data("prdata[7:0]", model_regs[reg_addr_t'(addr - addr_reg_base)], rdata[7:0]);
        end else if (addr == addr_flags) begin
            check_slverr("pslverr", 1'b0, slverr);
            check_data("prdata[15:8]", '0, rdata[15:8]);
            check_data("prdata[7:2]", '0, {2'b00, rdata[7:2]});
            check_flags("flags", model_flags, flags_t'(rdata[1:0]));
        end else begin
            check_slverr("pslverr", 1'b1, slverr);
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < reg_count; i++) begin
            read_check(addr_reg_base + paddr_t'(i));
        end
        read_check(addr_flags);
    endtask

    task automatic run_op(input logic [3:0] op, input reg_addr_t dst,
                          input reg_addr_t src_l, input reg_addr_t src_r);
        write_check(addr_instr, instr_word(op, dst, src_l, src_r));
        read_check(addr_reg_base + paddr_t'(dst));
        read_check(addr_flags);
    endtask

    initial begin
        paddr_t    addr;
        reg_addr_t prev;
        reg_addr_t dst;
        reg_addr_t other;
        apb_req     = '0;
        lfsr_state  = 32'h1053;
        model_flags = '0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        wait_reset_release();

        // everything reads as zero out of reset
        read_all();

        // direct writes to random registers
        repeat (16) begin
            addr = addr_reg_base + paddr_t'(rand_bits(2));
            write_check(addr, {8'h00, 8'(rand_bits(8))});
            read_check(addr);
        end

        // operands picked so that add, sub and both shifts produce a carry and xor gives zero
        write_check(3'd0, 16'h00c3);
        write_check(3'd1, 16'h007f);
        run_op(op_add, 2'd2, 2'd0, 2'd1);
        run_op(op_sub, 2'd3, 2'd1, 2'd0);
        run_op(op_shl, 2'd2, 2'd0, 2'd0);
        run_op(op_shr, 2'd3, 2'd0, 2'd1);
        run_op(op_xor, 2'd2, 2'd1, 2'd1);

        // every opcode on random registers
        for (int op = 0; op < 8; op++) begin
            repeat (4) begin
                run_op(4'(op), 2'(rand_bits(2)), 2'(rand_bits(2)), 2'(rand_bits(2)));
            end
        end

        // chains where each result feeds the next instruction, read back without a gap
        repeat (6) begin
            prev = 2'(rand_bits(2));
            repeat (4) begin
                dst   = 2'(rand_bits(2));
                other = 2'(rand_bits(2));
                if (rand_bits(1) != 0) begin
                    write_check(addr_instr, instr_word(4'(rand_bits(3)), dst, prev, other));
                end else begin
                    write_check(addr_instr, instr_word(4'(rand_bits(3)), dst, other, prev));
                end
                prev = dst;
            end
            read_all();
        end

        // error responses, none of them may touch the registers or flags
        write_check(3'd6, 16'(rand_bits(16)));
        write_check(3'd7, 16'(rand_bits(16)));
        read_check(3'd6);
        read_check(3'd7);
        read_check(addr_instr);
        repeat (8) begin
            write_check(addr_instr, instr_word({1'b1, 3'(rand_bits(3))}, 2'(rand_bits(2)),
                                               2'(rand_bits(2)), 2'(rand_bits(2))));
        end
        read_all();

        // random mix over the whole address map
        repeat (300) begin
            addr = paddr_t'(rand_bits(3));
            if (rand_bits(1) != 0) begin
                if (addr == addr_instr && rand_bits(1) != 0) begin
                    write_check(addr, instr_word(4'(rand_bits(3)), 2'(rand_bits(2)),
                                                 2'(rand_bits(2)), 2'(rand_bits(2))));
                end else begin
                    write_check(addr, 16'(rand_bits(16)));
                end
            end else begin
                read_check(addr);
            end
        end
        read_all();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic _wr_en,
    output logic arst_n
);

    // the clock runs freely with 10 time units per period
    initial begin
        _wr_en = 1'b0;
        forever begin
            #5 _wr_en = ~_wr_en;
        end
    end

    // reset is held over five rising edges and let go just after the last one
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge _wr_en);
        #1 arst_n = 1'b1;
    end

endmodule

// ==== source/alu_unit_top.sv ====
module alu_unit_top (
    input  logic              _wr_en,
    input  logic              arst_n,
    input  alu_pkg::apb_req_t apb_req,
    output alu_pkg::apb_rsp_t apb_rsp
);
    import alu_pkg::*;

    decode_t   dec_q;
    exec_t     exec_q;
    flags_t    flags;
    rf_write_t rf_wr;
    rf_write_t wr;
    logic      rd_l_en;
    logic      rd_r_en;
    reg_addr_t rd_l_addr;
    reg_addr_t rd_r_addr;
    data_t     rd_l_data;
    data_t     rd_r_data;

    // decode stage and APB slave
    alu_issue i_alu_issue (
        ._wr_en    (_wr_en),
        .arst_n    (arst_n),
        .apb_req   (apb_req),
        .exec_q    (exec_q),
        .flags     (flags),
        .rd_l_data (rd_l_data),
        .apb_rsp   (apb_rsp),
        .dec_q     (dec_q),
        .rd_l_en   (rd_l_en),
        .rd_r_en   (rd_r_en),
        .rd_l_addr (rd_l_addr),
        .rd_r_addr (rd_r_addr),
        .rf_wr     (rf_wr)
    );

    // execute stage reads both ports in the cycle after decode
    alu_execute i_alu_execute (
        ._wr_en    (_wr_en),
        .arst_n    (arst_n),
        .dec_q     (dec_q),
        .rd_l_data (rd_l_data),
        .rd_r_data (rd_r_data),
        .exec_q    (exec_q)
    );

    // result stage owns the write port and the flags
    alu_writeback i_alu_writeback (
        ._wr_en (_wr_en),
        .arst_n (arst_n),
        .exec_q (exec_q),
        .rf_wr  (rf_wr),
        .wr     (wr),
        .flags  (flags)
    );

    reg_file_2r1w i_reg_file_2r1w (
        ._wr_en    (_wr_en),
        .arst_n    (arst_n),
        .wr        (wr),
        .rd_l_en   (rd_l_en),
        .rd_r_en   (rd_r_en),
        .rd_l_addr (rd_l_addr),
        .rd_r_addr (rd_r_addr),
        .rd_l_data (rd_l_data),
        .rd_r_data (rd_r_data)
    );

endmodule

// ==== source/alu_writeback.sv ====
module alu_writeback (
    input  logic               _wr_en,
    input  logic               arst_n,
    input  alu_pkg::exec_t     exec_q,
    input  alu_pkg::rf_write_t rf_wr,
    output alu_pkg::rf_write_t wr,
    output alu_pkg::flags_t    flags
);
    import alu_pkg::*;

    // write request formed from the finished instruction
    rf_write_t pipe_wr;

    assign pipe_wr = '{
        en:   1'b1,
        addr: exec_q.dst,
        data: exec_q.result
    };

    // the pipeline wins the write port
    // a direct write only completes on an empty pipeline so the two never meet
    assign wr = exec_q.valid ? pipe_wr : rf_wr;

    // flags follow the last instruction and direct writes leave them alone
    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (exec_q.valid) begin
            flags.carry <= exec_q.carry;
            flags.zero  <= exec_q.zero;
        end
    end

endmodule

// ==== source/alu_execute.sv ====
module alu_execute (
    input  logic             _wr_en,
    input  logic             arst_n,
    input  alu_pkg::decode_t dec_q,
    input  alu_pkg::data_t   rd_l_data,
    input  alu_pkg::data_t   rd_r_data,
    output alu_pkg::exec_t   exec_q
);
    import alu_pkg::*;

    data_t result;
    logic  carry;

    // operands arrive from the register file in the cycle after decode
    always_comb begin
        logic [data_w:0] wide;
        wide   = '0;
        result = '0;
        carry  = 1'b0;
        case (dec_q.op)
            op_add: begin
                wide   = {1'b0, rd_l_data} + {1'b0, rd_r_data};
                result = wide[data_w-1:0];
                carry  = wide[data_w];
            end
            op_sub: begin
                // the extra bit comes out as one when L is below R, which is the borrow
                wide   = {1'b0, rd_l_data} - {1'b0, rd_r_data};
                result = wide[data_w-1:0];
                carry  = wide[data_w];
            end
            op_and: result = rd_l_data & rd_r_data;
            op_or:  result = rd_l_data | rd_r_data;
            op_xor: result = rd_l_data ^ rd_r_data;
            op_mov: result = rd_l_data;
            op_shl: begin
                result = {rd_l_data[data_w-2:0], 1'b0};
                carry  = rd_l_data[data_w-1];
            end
            op_shr: begin
                result = {1'b0, rd_l_data[data_w-1:1]};
                carry  = rd_l_data[0];
            end
            // illegal opcodes never reach decode
            default: begin
                result = '0;
                carry  = 1'b0;
            end
        endcase
    end

    // the execute pipeline register moves its payload only with a valid instruction
    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            exec_q <= '0;
        end else begin
            exec_q.valid <= dec_q.valid;
            if (dec_q.valid) begin
                exec_q.dst    <= dec_q.dst;
                exec_q.result <= result;
                exec_q.carry  <= carry;
                exec_q.zero   <= result == '0;
            end
        end
    end

endmodule

// ==== source/alu_issue.sv ====
module alu_issue (
    input  logic                _wr_en,
    input  logic                arst_n,
    input  alu_pkg::apb_req_t   apb_req,
    input  alu_pkg::exec_t      exec_q,
    input  alu_pkg::flags_t     flags,
    input  alu_pkg::data_t      rd_l_data,
    output alu_pkg::apb_rsp_t   apb_rsp,
    output alu_pkg::decode_t    dec_q,
    output logic                rd_l_en,
    output logic                rd_r_en,
    output alu_pkg::reg_addr_t  rd_l_addr,
    output alu_pkg::reg_addr_t  rd_r_addr,
    output alu_pkg::rf_write_t  rf_wr
);
    import alu_pkg::*;

    instr_t           instr;
    reg_addr_t        apb_reg;
    logic             access;
    logic             is_reg;
    logic             is_instr;
    logic             is_flags;
    logic             is_unmapped;
    logic             op_illegal;
    logic             pipe_busy;
    logic             hazard;
    logic             ready;
    logic             error;
    logic             complete;
    logic             accept;
    logic             rd_apb;
    logic [apb_w-1:0] rdata;

    // a write to addr_instr carries the instruction word on pwdata
    assign instr = instr_t'(apb_req.pwdata);

    // access phase of the current transfer, stretched for as long as ready stays low
    assign access = apb_req.psel & apb_req.penable;

    // address decode
    assign is_reg      = (apb_req.paddr - addr_reg_base) < paddr_t'(reg_count);
    assign is_instr    = apb_req.paddr == addr_instr;
    assign is_flags    = apb_req.paddr == addr_flags;
    assign is_unmapped = !(is_reg || is_instr || is_flags);
    assign apb_reg     = reg_addr_t'(apb_req.paddr - addr_reg_base);

    // only the first eight opcodes exist
    assign op_illegal = instr.op > op_shr;

    // something is still on its way to the register file
    assign pipe_busy = dec_q.valid | exec_q.valid;

    // read after write against both in-flight stages
    // the exec stage check is conservative and costs at most one cycle
    assign hazard = (dec_q.valid
                        && (dec_q.dst == instr.src_l || dec_q.dst == instr.src_r))
                 || (exec_q.valid
                        && (exec_q.dst == instr.src_l || exec_q.dst == instr.src_r));

    // ready and error for the transfer on the bus
    // errors finish at once while direct register and flags access waits for an empty pipeline
    always_comb begin
        ready = 1'b0;
        error = 1'b0;
        if (is_unmapped) begin
            ready = 1'b1;
            error = 1'b1;
        end else if (is_instr) begin
            if (!apb_req.pwrite || op_illegal) begin
                ready = 1'b1;
                error = 1'b1;
            end else begin
                ready = !hazard;
            end
        end else begin
            ready = !pipe_busy;
        end
    end

    // transfer finishes at the next rising edge
    assign complete = access & ready;

    // a legal instruction enters the decode register on its completing edge
    assign accept = complete & apb_req.pwrite & is_instr & !error;

    // direct register writes go straight to the write port and writeback arbitrates
    assign rf_wr = '{
        en:   complete & apb_req.pwrite & is_reg,
        addr: apb_reg,
        data: apb_req.pwdata[data_w-1:0]
    };

    // port L is borrowed by an APB register read only while decode does not need it
    // the read cannot complete before decode has drained anyway
    assign rd_apb = access & !apb_req.pwrite & is_reg & !dec_q.valid;

    assign rd_l_en   = rd_apb | dec_q.valid;
    assign rd_l_addr = rd_apb ? apb_reg : dec_q.src_l;
    assign rd_r_en   = dec_q.valid;
    assign rd_r_addr = dec_q.src_r;

    // read data is zero extended to the bus width
    always_comb begin
        rdata = '0;
        if (!apb_req.pwrite) begin
            if (is_reg) begin
                rdata = {{(apb_w-data_w){1'b0}}, rd_l_data};
            end else if (is_flags) begin
                rdata = {{(apb_w-$bits(flags_t)){1'b0}}, flags};
            end
        end
    end

    // slverr is only meaningful in the completing cycle
    assign apb_rsp = '{
        prdata:  rdata,
        pready:  complete,
        pslverr: complete & error
    };

    // decode pipeline register
    // valid lasts one cycle since a new transfer needs at least a setup cycle first
    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            dec_q <= '0;
        end else begin
            dec_q.valid <= accept;
            if (accept) begin
                dec_q.op    <= opcode_t'(instr.op);
                dec_q.dst   <= instr.dst;
                dec_q.src_l <= instr.src_l;
                dec_q.src_r <= instr.src_r;
            end
        end
    end

endmodule

// ==== source/reg_file_2r1w.sv ====
module reg_file_2r1w (
    input  logic                _wr_en,
    input  logic                arst_n,
    input  alu_pkg::rf_write_t  wr,
    input  logic                rd_l_en,
    input  logic                rd_r_en,
    input  alu_pkg::reg_addr_t  rd_l_addr,
    input  alu_pkg::reg_addr_t  rd_r_addr,
    output alu_pkg::data_t      rd_l_data,
    output alu_pkg::data_t      rd_r_data
);
    import alu_pkg::*;

    // the architectural registers, all zero out of reset
    data_t regs [reg_count];

    // one write port, taken at the rising edge
    always_ff @(posedge _wr_en or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // read ports are purely combinational
    // a disabled port returns zero
    assign rd_l_data = rd_l_en ? regs[rd_l_addr] : '0;
    assign rd_r_data = rd_r_en ? regs[rd_r_addr] : '0;

endmodule

// ==== source/alu_pkg.sv ====
package alu_pkg;

    // datapath width and register count are fixed by the instruction encoding
    localparam int data_w    = 8;
    localparam int reg_count = 4;

    // the APB data bus is wider than the datapath to carry a whole instruction word
    localparam int apb_w = 16;

    typedef logic [data_w-1:0]            data_t;
    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;
    typedef logic [2:0]                   paddr_t;

    // opcodes 8 to 15 are not defined and get an error response
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_mov = 4'd5,
        op_shl = 4'd6,
        op_shr = 4'd7
    } opcode_t;

    // the four registers sit at the bottom of the map
    localparam paddr_t addr_reg_base = 3'd0;
    localparam paddr_t addr_instr    = 3'd4;
    localparam paddr_t addr_flags    = 3'd5;

    typedef struct packed {
        logic             psel;
        logic             penable;
        logic             pwrite;
        paddr_t           paddr;
        logic [apb_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_w-1:0] prdata;
        logic             pready;
        logic             pslverr;
    } apb_rsp_t;

    // instruction word as written to addr_instr
    // the op field stays raw so that illegal values can be detected
    typedef struct packed {
        logic [3:0] op;
        reg_addr_t  dst;
        reg_addr_t  src_l;
        reg_addr_t  src_r;
        logic [5:0] unused;
    } instr_t;

    typedef struct packed {
        logic      valid;
        opcode_t   op;
        reg_addr_t dst;
        reg_addr_t src_l;
        reg_addr_t src_r;
    } decode_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dst;
        data_t     result;
        logic      carry;
        logic      zero;
    } exec_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        data_t     data;
    } rf_write_t;

    typedef struct packed {
        logic carry;
        logic zero;
    } flags_t;

endpackage
